// File: verilog/fc_pkg.sv
`default_nettype none

package fc_pkg;

  // ==========================================================================
  // Layer geometry
  // ==========================================================================

  // Byte address space of the shared memory
  localparam int ADDR_WIDTH = 19;

  // One fetch carries 32 elements
  localparam int CHUNK_BYTES = 32;
  localparam int CHUNKS_PER_ROW = 4;

  // Weight row stride, one byte per element
  localparam int ROW_BYTES = CHUNK_BYTES * CHUNKS_PER_ROW;

  // Row count of a single command
  localparam int MAX_ROWS = 128;
  localparam int ROW_CNT_WIDTH = 8;

  // Bias words are 32 bit, packed back to back
  localparam int BIAS_BYTES = 4;

  // Dot product and activation
  localparam int ACC_WIDTH = 32;
  // Weight scale 7 plus ReLU factor 1
  localparam int LOG2_SCALE = 8;

  // ==========================================================================
  // Types
  // ==========================================================================

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  typedef logic [7:0] data_byte_t;
  typedef logic signed [7:0] wgt_byte_t;

  // Element 0 sits in the low byte
  typedef data_byte_t [CHUNK_BYTES-1:0] data_vec_t;
  typedef wgt_byte_t [CHUNK_BYTES-1:0] wgt_vec_t;

  typedef logic signed [8*BIAS_BYTES-1:0] bias_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // Command as written by the host
  typedef struct packed {
    addr_t addr_x;
    addr_t addr_y;
    addr_t addr_b;
    addr_t addr_z;
    logic [ROW_CNT_WIDTH-1:0] num_rows;
  } fc_cmd_t;

  // Read request, address only
  typedef struct packed {
    addr_t addr;
  } mem_req_t;

  // Single byte write
  typedef struct packed {
    addr_t addr;
    logic [7:0] data;
  } mem_wr_t;

endpackage

`default_nettype wire

// File: verilog/fc_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module fc_read_port #(
  parameter type payload_t = logic [7:0]
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue,
  input  logic             consume,
  input  fc_pkg::addr_t    addr,
  output fc_pkg::mem_req_t req,
  output logic             req_valid,
  input  logic             req_ready,
  input  logic             rsp_valid,
  input  payload_t         rsp,
  output logic             loaded,
  output payload_t         payload
);

  // Request taken by memory, answer still due
  logic pending_q;

  // ==========================================================================
  // Request / response tracking
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_valid <= 1'b0;
      pending_q <= 1'b0;
      loaded    <= 1'b0;
    end
    else
    begin
      // Hold request until handshake
      if (issue)
        req_valid <= 1'b1;
      else if (req_valid && req_ready)
        req_valid <= 1'b0;

      if (req_valid && req_ready)
        pending_q <= 1'b1;
      else if (rsp_valid)
        pending_q <= 1'b0;

      // Stays up until the sequencer has used it
      if (rsp_valid)
        loaded <= 1'b1;
      else if (consume)
        loaded <= 1'b0;
    end
  end

  // Address and returned payload
  always_ff @(posedge clk)
  begin
    if (issue)
      req.addr <= addr;
    if (rsp_valid)
      payload <= rsp;
  end

  // Single outstanding request per port
  a_issue_when_free : assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> !(req_valid || pending_q || loaded));

  a_rsp_expected : assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> pending_q);

endmodule

`default_nettype wire

// File: verilog/fc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fc_sequencer (
  input  logic            clk,
  input  logic            rst_n,
  input  fc_pkg::fc_cmd_t cmd,
  input  logic            cmd_valid,
  output logic            cmd_ready,
  output logic            data_issue,
  output logic            wgt_issue,
  output logic            bias_issue,
  output fc_pkg::addr_t   data_addr,
  output fc_pkg::addr_t   wgt_addr,
  output fc_pkg::addr_t   bias_addr,
  input  logic            data_loaded,
  input  logic            wgt_loaded,
  input  logic            bias_loaded,
  output logic            consume,
  output logic            chunk_valid,
  output logic            chunk_first,
  output logic            chunk_last,
  output fc_pkg::addr_t   wr_addr,
  input  logic            row_written,
  output logic            busy,
  output logic            done
);

  import fc_pkg::*;

  localparam int CHUNK_CNT_WIDTH = $clog2(CHUNKS_PER_ROW);
  localparam logic [CHUNK_CNT_WIDTH-1:0] LAST_CHUNK = CHUNK_CNT_WIDTH'(CHUNKS_PER_ROW - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_ACCUM,
    S_WAIT_WR
  } state_t;

  state_t state_q;
  fc_cmd_t cmd_q;
  fc_cmd_t base;
  logic [ROW_CNT_WIDTH-1:0] row_q;
  logic [CHUNK_CNT_WIDTH-1:0] chunk_q;
  logic issue_q;
  logic start;
  logic last_row;
  logic operands_ready;
  addr_t chunk_off;

  // ==========================================================================
  // Command decode
  // ==========================================================================

  // No new command in the done cycle
  assign cmd_ready = (state_q == S_IDLE) && !done;
  assign start     = cmd_valid && cmd_ready;
  assign busy      = (state_q != S_IDLE) || done;

  always_ff @(posedge clk)
  begin
    if (start)
      cmd_q <= cmd;
  end

  // First fetch is issued in the accept cycle, before cmd_q is loaded
  assign base = (state_q == S_IDLE) ? cmd : cmd_q;

  // ==========================================================================
  // Address generation
  // ==========================================================================
  assign chunk_off = addr_t'(chunk_q) * addr_t'(CHUNK_BYTES);

  assign data_addr = base.addr_x + chunk_off;
  assign wgt_addr  = base.addr_y + addr_t'(row_q) * addr_t'(ROW_BYTES) + chunk_off;
  assign bias_addr = base.addr_b + addr_t'(row_q) * addr_t'(BIAS_BYTES);
  assign wr_addr   = cmd_q.addr_z + addr_t'(row_q);

  // Bias once per row, with chunk 0
  assign data_issue = start || issue_q;
  assign wgt_issue  = data_issue;
  assign bias_issue = start || (issue_q && chunk_q == '0);

  // ==========================================================================
  // Chunk hand-off to the accumulator
  // ==========================================================================
  assign operands_ready = data_loaded && wgt_loaded && (bias_loaded || chunk_q != '0);

  assign chunk_valid = (state_q == S_ACCUM);
  assign consume     = chunk_valid;
  assign chunk_first = chunk_valid && (chunk_q == '0);
  assign chunk_last  = chunk_valid && (chunk_q == LAST_CHUNK);

  assign last_row = (row_q == cmd_q.num_rows - 1'b1);

  // ==========================================================================
  // Row / chunk FSM
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= S_IDLE;
      row_q   <= '0;
      chunk_q <= '0;
      issue_q <= 1'b0;
      done    <= 1'b0;
    end
    else
    begin
      issue_q <= 1'b0;
      done    <= 1'b0;
      case (state_q)
        S_IDLE:
        begin
          if (start)
            state_q <= S_FETCH;
        end
        // Wait for all operands of this chunk
        S_FETCH:
        begin
          if (operands_ready)
            state_q <= S_ACCUM;
        end
        S_ACCUM:
        begin
          if (chunk_last)
          begin
            chunk_q <= '0;
            state_q <= S_WAIT_WR;
          end
          else
          begin
            chunk_q <= chunk_q + 1'b1;
            issue_q <= 1'b1;
            state_q <= S_FETCH;
          end
        end
        // Row result leaves through the writer
        S_WAIT_WR:
        begin
          if (row_written)
          begin
            if (last_row)
            begin
              row_q   <= '0;
              done    <= 1'b1;
              state_q <= S_IDLE;
            end
            else
            begin
              row_q   <= row_q + 1'b1;
              issue_q <= 1'b1;
              state_q <= S_FETCH;
            end
          end
        end
        default:
        begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  a_num_rows_legal : assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (cmd.num_rows != '0 && cmd.num_rows <= MAX_ROWS));

endmodule

`default_nettype wire

// File: verilog/fc_dot_accum.sv
`timescale 1ns/1ps
`default_nettype none

module fc_dot_accum (
  input  logic              clk,
  input  logic              rst_n,
  input  fc_pkg::data_vec_t data,
  input  fc_pkg::wgt_vec_t  wgt,
  input  logic              chunk_valid,
  input  logic              chunk_first,
  input  logic              chunk_last,
  output logic              sum_valid,
  output fc_pkg::acc_t      sum
);

  import fc_pkg::*;

  acc_t prod [CHUNK_BYTES];
  acc_t chunk_sum;

  // ==========================================================================
  // 32-lane multiply-add
  // ==========================================================================

  // Unsigned data times signed weight, each lane 17 bit wide at most
  always_comb
  begin
    for (int i = 0; i < CHUNK_BYTES; i++)
    begin
      prod[i] = acc_t'(signed'({1'b0, data[i]})) * acc_t'(wgt[i]);
    end
  end

  // Adder tree over the lanes
  always_comb
  begin
    chunk_sum = '0;
    for (int i = 0; i < CHUNK_BYTES; i++)
    begin
      chunk_sum = chunk_sum + prod[i];
    end
  end

  // ==========================================================================
  // Row accumulator
  // ==========================================================================

  // First chunk restarts the row
  always_ff @(posedge clk)
  begin
    if (chunk_valid)
    begin
      if (chunk_first)
        sum <= chunk_sum;
      else
        sum <= sum + chunk_sum;
    end
  end

  // Row sum is complete one cycle after the last chunk
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sum_valid <= 1'b0;
    else
      sum_valid <= chunk_valid && chunk_last;
  end

endmodule

`default_nettype wire

// File: verilog/fc_activate_write.sv
`timescale 1ns/1ps
`default_nettype none

module fc_activate_write (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sum_valid,
  input  fc_pkg::acc_t    sum,
  input  fc_pkg::bias_t   bias,
  input  fc_pkg::addr_t   wr_addr,
  output fc_pkg::mem_wr_t wr,
  output logic            wr_valid,
  input  logic            wr_ready,
  output logic            row_written
);

  import fc_pkg::*;

  localparam acc_t BYTE_MAX = 255;

  acc_t pre_act;
  acc_t scaled;
  logic [7:0] act_byte;

  // ==========================================================================
  // Bias add and scaled ReLU
  // ==========================================================================
  always_comb
  begin
    pre_act = sum + bias;
    scaled  = pre_act >>> LOG2_SCALE;
    // Negative or zero clamps to 0
    if (pre_act <= 0)
      act_byte = '0;
    // Saturate to the unsigned byte range
    else if (scaled > BYTE_MAX)
      act_byte = 8'hff;
    else
      act_byte = scaled[7:0];
  end

  // ==========================================================================
  // Output write
  // ==========================================================================

  // Address and byte captured with the row sum
  always_ff @(posedge clk)
  begin
    if (sum_valid)
    begin
      wr.addr <= wr_addr;
      wr.data <= act_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_valid <= 1'b0;
    else if (sum_valid)
      wr_valid <= 1'b1;
    else if (wr_ready)
      wr_valid <= 1'b0;
  end

  // Write accepted this cycle
  assign row_written = wr_valid && wr_ready;

  a_wr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr)));

endmodule

`default_nettype wire

// File: verilog/fc_layer.sv
`timescale 1ns/1ps
`default_nettype none

module fc_layer (
  input  logic              clk,
  input  logic              rst_n,
  // Command
  input  fc_pkg::fc_cmd_t   cmd,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  // Data read
  output fc_pkg::mem_req_t  data_req,
  output logic              data_req_valid,
  input  logic              data_req_ready,
  input  logic              data_rsp_valid,
  input  fc_pkg::data_vec_t data_rsp,
  // Weight read
  output fc_pkg::mem_req_t  wgt_req,
  output logic              wgt_req_valid,
  input  logic              wgt_req_ready,
  input  logic              wgt_rsp_valid,
  input  fc_pkg::wgt_vec_t  wgt_rsp,
  // Bias read
  output fc_pkg::mem_req_t  bias_req,
  output logic              bias_req_valid,
  input  logic              bias_req_ready,
  input  logic              bias_rsp_valid,
  input  fc_pkg::bias_t     bias_rsp,
  // Result write
  output fc_pkg::mem_wr_t   wr,
  output logic              wr_valid,
  input  logic              wr_ready,
  // Status
  output logic              busy,
  output logic              done
);

  import fc_pkg::*;

  logic data_issue;
  logic wgt_issue;
  logic bias_issue;
  logic data_loaded;
  logic wgt_loaded;
  logic bias_loaded;
  logic consume;
  addr_t data_addr;
  addr_t wgt_addr;
  addr_t bias_addr;
  addr_t wr_addr;
  data_vec_t data_payload;
  wgt_vec_t wgt_payload;
  bias_t bias_payload;
  logic chunk_valid;
  logic chunk_first;
  logic chunk_last;
  logic sum_valid;
  acc_t sum;
  logic row_written;

  // ==========================================================================
  // Read ports
  // ==========================================================================
  fc_read_port #(.payload_t(data_vec_t)) i_data_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (data_issue),
    .consume   (consume),
    .addr      (data_addr),
    .req       (data_req),
    .req_valid (data_req_valid),
    .req_ready (data_req_ready),
    .rsp_valid (data_rsp_valid),
    .rsp       (data_rsp),
    .loaded    (data_loaded),
    .payload   (data_payload)
  );

  fc_read_port #(.payload_t(wgt_vec_t)) i_wgt_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (wgt_issue),
    .consume   (consume),
    .addr      (wgt_addr),
    .req       (wgt_req),
    .req_valid (wgt_req_valid),
    .req_ready (wgt_req_ready),
    .rsp_valid (wgt_rsp_valid),
    .rsp       (wgt_rsp),
    .loaded    (wgt_loaded),
    .payload   (wgt_payload)
  );

  // Bias payload stays valid until the next row fetch
  fc_read_port #(.payload_t(bias_t)) i_bias_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (bias_issue),
    .consume   (consume),
    .addr      (bias_addr),
    .req       (bias_req),
    .req_valid (bias_req_valid),
    .req_ready (bias_req_ready),
    .rsp_valid (bias_rsp_valid),
    .rsp       (bias_rsp),
    .loaded    (bias_loaded),
    .payload   (bias_payload)
  );

  // ==========================================================================
  // Decode, execute, result
  // ==========================================================================
  fc_sequencer i_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .data_issue  (data_issue),
    .wgt_issue   (wgt_issue),
    .bias_issue  (bias_issue),
    .data_addr   (data_addr),
    .wgt_addr    (wgt_addr),
    .bias_addr   (bias_addr),
    .data_loaded (data_loaded),
    .wgt_loaded  (wgt_loaded),
    .bias_loaded (bias_loaded),
    .consume     (consume),
    .chunk_valid (chunk_valid),
    .chunk_first (chunk_first),
    .chunk_last  (chunk_last),
    .wr_addr     (wr_addr),
    .row_written (row_written),
    .busy        (busy),
    .done        (done)
  );

  fc_dot_accum i_dot_accum (
    .clk         (clk),
    .rst_n       (rst_n),
    .data        (data_payload),
    .wgt         (wgt_payload),
    .chunk_valid (chunk_valid),
    .chunk_first (chunk_first),
    .chunk_last  (chunk_last),
    .sum_valid   (sum_valid),
    .sum         (sum)
  );

  fc_activate_write i_activate_write (
    .clk         (clk),
    .rst_n       (rst_n),
    .sum_valid   (sum_valid),
    .sum         (sum),
    .bias        (bias_payload),
    .wr_addr     (wr_addr),
    .wr          (wr),
    .wr_valid    (wr_valid),
    .wr_ready    (wr_ready),
    .row_written (row_written)
  );

endmodule

`default_nettype wire

// File: tb/tb_fc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fc_mem (
  input  logic              clk,
  input  logic              rst_n,
  input  fc_pkg::mem_req_t  data_req,
  input  logic              data_req_valid,
  output logic              data_req_ready,
  output logic              data_rsp_valid,
  output fc_pkg::data_vec_t data_rsp,
  input  fc_pkg::mem_req_t  wgt_req,
  input  logic              wgt_req_valid,
  output logic              wgt_req_ready,
  output logic              wgt_rsp_valid,
  output fc_pkg::wgt_vec_t  wgt_rsp,
  input  fc_pkg::mem_req_t  bias_req,
  input  logic              bias_req_valid,
  output logic              bias_req_ready,
  output logic              bias_rsp_valid,
  output fc_pkg::bias_t     bias_rsp,
  output logic              wr_ready
);

  import fc_pkg::*;

  localparam int MEM_BYTES = 1 << ADDR_WIDTH;
  localparam int MAX_DELAY = 4;

  // Byte storage, filled by the testbench before each command
  logic [7:0] mem [MEM_BYTES];

  // Per channel: data, wgt, bias
  logic [2:0] req_hs;
  addr_t req_addr [3];
  addr_t rd_addr [3];
  // Cycles left to the answer, 0 when idle
  logic [2:0] wait_cnt [3];

  assign req_hs = {bias_req_valid && bias_req_ready, wgt_req_valid && wgt_req_ready,
                   data_req_valid && data_req_ready};
  assign req_addr[0] = data_req.addr;
  assign req_addr[1] = wgt_req.addr;
  assign req_addr[2] = bias_req.addr;

  // Little endian gather, byte 0 in the low bits
  function automatic logic [255:0] read_bytes(addr_t base, int nbytes);
    logic [255:0] v;
    v = '0;
    for (int i = 0; i < nbytes; i++)
      v[8*i +: 8] = mem[addr_t'(base + i)];
    return v;
  endfunction

  // ==========================================================================
  // Random stalls and delayed answers
  // ==========================================================================
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_req_ready <= 1'b0;
      wgt_req_ready  <= 1'b0;
      bias_req_ready <= 1'b0;
      wr_ready       <= 1'b0;
      data_rsp_valid <= 1'b0;
      wgt_rsp_valid  <= 1'b0;
      bias_rsp_valid <= 1'b0;
      data_rsp       <= '0;
      wgt_rsp        <= '0;
      bias_rsp       <= '0;
      for (int ch = 0; ch < 3; ch++)
        wait_cnt[ch] <= '0;
    end
    else
    begin
      // Ready about three cycles in four, write ready half the time
      data_req_ready <= ($urandom % 4) != 0;
      wgt_req_ready  <= ($urandom % 4) != 0;
      bias_req_ready <= ($urandom % 4) != 0;
      wr_ready       <= ($urandom % 2) != 0;
      data_rsp_valid <= 1'b0;
      wgt_rsp_valid  <= 1'b0;
      bias_rsp_valid <= 1'b0;
      for (int ch = 0; ch < 3; ch++)
      begin
        if (req_hs[ch])
        begin
          rd_addr[ch]  <= req_addr[ch];
          wait_cnt[ch] <= 3'(1 + $urandom % MAX_DELAY);
        end
        else if (wait_cnt[ch] != 0)
          wait_cnt[ch] <= wait_cnt[ch] - 3'd1;
      end
      // One-cycle answer when the delay runs out
      if (wait_cnt[0] == 3'd1)
      begin
        data_rsp_valid <= 1'b1;
        data_rsp       <= data_vec_t'(read_bytes(rd_addr[0], CHUNK_BYTES));
      end
      if (wait_cnt[1] == 3'd1)
      begin
        wgt_rsp_valid <= 1'b1;
        wgt_rsp       <= wgt_vec_t'(read_bytes(rd_addr[1], CHUNK_BYTES));
      end
      if (wait_cnt[2] == 3'd1)
      begin
        bias_rsp_valid <= 1'b1;
        bias_rsp       <= bias_t'(read_bytes(rd_addr[2], BIAS_BYTES));
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_fc_layer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fc_layer;

  import fc_pkg::*;

  localparam int NUM_CMDS = 12;
  localparam int MAX_CMD_ROWS = 16;
  localparam int MAX_DELAY = 4;
  localparam int WR_STALL = 16;
  localparam int ROW_CYCLES = CHUNKS_PER_ROW * 3 * MAX_DELAY + WR_STALL;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * MAX_CMD_ROWS * ROW_CYCLES * 2;

  logic clk;
  logic rst_n;
  fc_cmd_t cmd;
  logic cmd_valid;
  logic cmd_ready;
  mem_req_t data_req;
  mem_req_t wgt_req;
  mem_req_t bias_req;
  logic data_req_valid;
  logic data_req_ready;
  logic data_rsp_valid;
  logic wgt_req_valid;
  logic wgt_req_ready;
  logic wgt_rsp_valid;
  logic bias_req_valid;
  logic bias_req_ready;
  logic bias_rsp_valid;
  data_vec_t data_rsp;
  wgt_vec_t wgt_rsp;
  bias_t bias_rsp;
  mem_wr_t wr;
  logic wr_valid;
  logic wr_ready;
  logic busy;
  logic done;

  // Expected traffic, in order
  addr_t exp_data_addr[$];
  addr_t exp_wgt_addr[$];
  addr_t exp_bias_addr[$];
  mem_wr_t exp_wr[$];
  int done_cnt = 0;
  int cycle_cnt = 0;
  logic in_cmd = 1'b0;

  fc_layer i_dut (.*);

  tb_fc_mem i_mem (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================================
  // Reporting
  // ==========================================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                          name, actual, expected));
  endtask

  task automatic check_request(input string name, input addr_t got, ref addr_t exp_q[$]);
    if (exp_q.size() == 0)
      abort_run($sformatf("%s was accepted while no read was expected", name));
    else
      check_value(name, 32'(got), 32'(exp_q.pop_front()));
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================

  // Scaled ReLU with saturation to a byte
  function automatic logic [7:0] activate(longint pre);
    longint scaled;
    if (pre <= 0)
      return 8'h00;
    scaled = pre >>> LOG2_SCALE;
    if (scaled > 255)
      return 8'hff;
    return 8'(scaled);
  endfunction

  // Mode 1 bias far negative, 2 far positive, 3 extreme weights
  task automatic prepare_command(input int idx, output fc_cmd_t c);
    int rows;
    int mode;
    logic [7:0] x [ROW_BYTES];
    logic signed [7:0] w;
    logic signed [31:0] b;
    longint acc;
    mem_wr_t e;
    rows = (idx == 0) ? 1 : 1 + int'($urandom % MAX_CMD_ROWS);
    mode = idx % 4;
    // Disjoint areas for inputs, weights, biases and results
    c.addr_x = addr_t'($urandom % 32'h1_0000);
    c.addr_y = addr_t'(32'h2_0000 + $urandom % 32'h1_0000);
    c.addr_b = addr_t'(32'h4_0000 + $urandom % 32'h1_0000);
    c.addr_z = addr_t'(32'h6_0000 + $urandom % 32'h1_0000);
    c.num_rows = ROW_CNT_WIDTH'(rows);
    for (int k = 0; k < ROW_BYTES; k++)
    begin
      x[k] = 8'($urandom);
      i_mem.mem[addr_t'(c.addr_x + k)] = x[k];
    end
    for (int r = 0; r < rows; r++)
    begin
      acc = 0;
      for (int k = 0; k < ROW_BYTES; k++)
      begin
        if (mode == 3)
          w = ($urandom % 2 != 0) ? 8'sd127 : -8'sd128;
        else
          w = 8'($urandom);
        i_mem.mem[addr_t'(c.addr_y + r * ROW_BYTES + k)] = w;
        acc += longint'(x[k]) * longint'(w);
      end
      b = 32'($urandom % 32'h4_0000) - 32'sh2_0000;
      if (mode == 1 || mode == 2)
        b = 32'sh1000_0000 + 32'($urandom % 32'h10_0000);
      if (mode == 1)
        b = -b;
      for (int j = 0; j < BIAS_BYTES; j++)
        i_mem.mem[addr_t'(c.addr_b + r * BIAS_BYTES + j)] = b[8*j +: 8];
      acc += longint'(b);
      e.addr = addr_t'(c.addr_z + r);
      e.data = activate(acc);
      exp_wr.push_back(e);
      exp_bias_addr.push_back(addr_t'(c.addr_b + r * BIAS_BYTES));
      for (int ch = 0; ch < CHUNKS_PER_ROW; ch++)
      begin
        exp_data_addr.push_back(addr_t'(c.addr_x + ch * CHUNK_BYTES));
        exp_wgt_addr.push_back(addr_t'(c.addr_y + r * ROW_BYTES + ch * CHUNK_BYTES));
      end
    end
  endtask

  // ==========================================================================
  // Bus and status monitor
  // ==========================================================================
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (in_cmd)
      begin
        check_value("busy", 32'(busy), 32'd1);
        check_value("cmd_ready", 32'(cmd_ready), 32'd0);
      end
      else
      begin
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
      end
      if (data_req_valid && data_req_ready)
        check_request("data_req.addr", data_req.addr, exp_data_addr);
      if (wgt_req_valid && wgt_req_ready)
        check_request("wgt_req.addr", wgt_req.addr, exp_wgt_addr);
      if (bias_req_valid && bias_req_ready)
        check_request("bias_req.addr", bias_req.addr, exp_bias_addr);
      if (wr_valid && wr_ready)
      begin
        if (exp_wr.size() == 0)
          abort_run("A write was accepted while no row result was expected");
        else
        begin
          check_value("wr.addr", 32'(wr.addr), 32'(exp_wr[0].addr));
          check_value("wr.data", 32'(wr.data), 32'(exp_wr[0].data));
          void'(exp_wr.pop_front());
        end
      end
      // Every row written and every read issued by the done pulse
      if (done)
      begin
        check_value("rows_left", 32'(exp_wr.size()), 32'd0);
        check_value("data_reads_left", 32'(exp_data_addr.size()), 32'd0);
        check_value("wgt_reads_left", 32'(exp_wgt_addr.size()), 32'd0);
        check_value("bias_reads_left", 32'(exp_bias_addr.size()), 32'd0);
        done_cnt++;
        in_cmd = 1'b0;
      end
      if (cmd_valid && cmd_ready)
        in_cmd = 1'b1;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout, the run did not finish within %0d cycles",
                          TIMEOUT_CYCLES));
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial
  begin
    fc_cmd_t c;
    void'($urandom(75));
    rst_n = 1'b0;
    cmd = '0;
    cmd_valid = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Idle state right after reset
    @(negedge clk);
    check_value("data_req_valid", 32'(data_req_valid), 32'd0);
    check_value("wgt_req_valid", 32'(wgt_req_valid), 32'd0);
    check_value("bias_req_valid", 32'(bias_req_valid), 32'd0);
    check_value("wr_valid", 32'(wr_valid), 32'd0);
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    for (int n = 0; n < NUM_CMDS; n++)
    begin
      prepare_command(n, c);
      @(posedge clk);
      cmd <= c;
      cmd_valid <= 1'b1;
      do
        @(posedge clk);
      while (!cmd_ready);
      cmd_valid <= 1'b0;
      do
        @(posedge clk);
      while (!done);
    end
    @(posedge clk);
    if (done_cnt != NUM_CMDS)
      abort_run($sformatf("Saw %0d done pulses for %0d commands", done_cnt, NUM_CMDS));
    else
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: fc_layer.f
verilog/fc_pkg.sv
verilog/fc_read_port.sv
verilog/fc_sequencer.sv
verilog/fc_dot_accum.sv
verilog/fc_activate_write.sv
verilog/fc_layer.sv
tb/tb_fc_mem.sv
tb/tb_fc_layer.sv

// File: run.sh
#!/bin/sh
# Build and run the fc_layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f fc_layer.f \
  --top-module tb_fc_layer \
  -o tb_fc_layer

./obj_dir/tb_fc_layer
